//--- tb.f
+incdir+design
design/smePkg.sv
design/charStore.sv
design/patternStore.sv
design/windowCompare.sv
design/scanControl.sv
design/smeTop.sv
verification/tbClock.sv
verification/smeTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert --top-module smeTb -Mdir obj_dir -f tb.f \
    && ./obj_dir/VsmeTb > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -qF "*** FAILED ***" sim.log \
    || { echo "simulation failed"; exit 1; }

//--- verification/smeTb.sv
`timescale 1ns/10ps
`include "sme_cfg.svh"

module smeTb import smePkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int IN_DELAY = 5;
    // longest scan is one cycle per position plus the result cycle
    localparam int MAX_LATENCY = `SME_STR_LEN + 8;
    localparam int NUM_SCANS = 26;
    localparam int WATCHDOG_CYCLES = NUM_SCANS * 80 + RESET_CYCLES + 40;

    logic clk;
    logic reset;
    smeChar charData;
    logic isString;
    logic isPattern;
    logic valid;
    logic match;
    smeIndex matchIndex;

    string storedStr;
    int seed = 99;
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;

    tbClock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) tbClock_i (
        .clk   (clk),
        .reset (reset)
    );

    smeTop smeTop_i (
        .clk        (clk),
        .reset      (reset),
        .charData   (charData),
        .isString   (isString),
        .isPattern  (isPattern),
        .valid      (valid),
        .match      (match),
        .matchIndex (matchIndex)
    );

    // first match position under the ., ^ and $ rules
    function automatic void expectedResult(input string s, input string p,
                                           output bit expMatch, output smeIndex expIdx);
        bit anchorStart;
        bit anchorEnd;
        bit ok;
        int first;
        int last;
        int coreLen;
        anchorStart = 1'b0;
        anchorEnd = 1'b0;
        first = 0;
        last = p.len();
        expMatch = 1'b0;
        expIdx = '0;
        if (last > 0 && p[0] == `SME_CARET)
        begin
            anchorStart = 1'b1;
            first = 1;
        end
        if (last > first && p[last-1] == `SME_DOLLAR)
        begin
            anchorEnd = 1'b1;
            last = last - 1;
        end
        coreLen = last - first;
        for (int i = 0; i + coreLen <= s.len(); i++)
        begin
            ok = 1'b1;
            for (int k = 0; k < coreLen; k++)
            begin
                if (p[first+k] != `SME_DOT && p[first+k] != s[i+k])
                begin
                    ok = 1'b0;
                end
            end
            if (anchorStart && i != 0 && s[i-1] != `SME_SPACE)
            begin
                ok = 1'b0;
            end
            if (anchorEnd && i + coreLen != s.len() && s[i+coreLen] != `SME_SPACE)
            begin
                ok = 1'b0;
            end
            if (ok)
            begin
                expMatch = 1'b1;
                expIdx = smeIndex'(i);
                return;
            end
        end
    endfunction

    task automatic checkMatch(input bit actual, input bit expected, input string what);
        checkCount++;
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s is %0b, expected %0b", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic checkIndex(input smeIndex actual, input smeIndex expected, input string what);
        checkCount++;
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic loadString(input string s);
        for (int i = 0; i < s.len(); i++)
        begin
            @(posedge clk);
            #IN_DELAY;
            isString = 1'b1;
            charData = s[i];
        end
        @(posedge clk);
        #IN_DELAY;
        isString = 1'b0;
        storedStr = s;
    endtask

    task automatic waitValid(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < MAX_LATENCY && !seen; n++)
        begin
            @(negedge clk);
            seen = valid;
        end
    endtask

    // streams a pattern against the stored string and checks the result
    task automatic scanPattern(input string p);
        bit expMatch;
        smeIndex expIdx;
        bit seen;
        string what;
        what = $sformatf("'%s' on '%s'", p, storedStr);
        expectedResult(storedStr, p, expMatch, expIdx);
        for (int i = 0; i < p.len(); i++)
        begin
            @(posedge clk);
            #IN_DELAY;
            isPattern = 1'b1;
            charData = p[i];
        end
        @(posedge clk);
        #IN_DELAY;
        isPattern = 1'b0;
        waitValid(seen);
        if (!seen)
        begin
            $display("no valid from the DUT within %0d cycles for %s", MAX_LATENCY, what);
            errorCount++;
        end
        else
        begin
            checkMatch(match, expMatch, {"match for ", what});
            checkIndex(matchIndex, expIdx, {"matchIndex for ", what});
            @(negedge clk);
            checkMatch(valid, 1'b0, {"valid a cycle after ", what});
            checkMatch(match, expMatch, {"held match for ", what});
            checkIndex(matchIndex, expIdx, {"held matchIndex for ", what});
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: %0d error(s)", name, errorCount - errorsBefore);
        end
    endtask

    // outputs idle during and after reset
    task automatic idleAfterReset();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (2) @(negedge clk);
        checkMatch(valid, 1'b0, "valid in reset");
        @(negedge reset);
        repeat (4)
        begin
            @(negedge clk);
            checkMatch(valid, 1'b0, "valid after reset");
            checkMatch(match, 1'b0, "match after reset");
            checkIndex(matchIndex, '0, "matchIndex after reset");
        end
        reportTest("resetState", errorsBefore);
    endtask

    task automatic literalPatterns();
        int errorsBefore;
        errorsBefore = errorCount;
        loadString("the quick brown fox");
        scanPattern("brown");
        scanPattern("cat");
        scanPattern("fox");
        reportTest("literal", errorsBefore);
    endtask

    task automatic dotWildcard();
        int errorsBefore;
        errorsBefore = errorCount;
        loadString("a b c xyz");
        scanPattern("a.b");
        scanPattern("x.z");
        scanPattern("q..");
        reportTest("dot", errorsBefore);
    endtask

    task automatic caretAnchor();
        int errorsBefore;
        errorsBefore = errorCount;
        loadString("xcat cab cat");
        scanPattern("^cat");
        scanPattern("^ca");
        scanPattern("cat");
        scanPattern("^xc");
        reportTest("caret", errorsBefore);
    endtask

    task automatic dollarAnchor();
        int errorsBefore;
        errorsBefore = errorCount;
        loadString("ran brand and");
        scanPattern("^and$");
        scanPattern("and$");
        scanPattern("^bra$");
        scanPattern("ra.$");
        reportTest("dollar", errorsBefore);
    endtask

    // one stored string against fixed then random patterns taken from it
    task automatic stringReuse();
        int errorsBefore;
        int start;
        int plen;
        string p;
        errorsBefore = errorCount;
        loadString("one two three four five six nine");
        scanPattern("two");
        scanPattern("^nine$");
        scanPattern("fiv. six");
        for (int r = 0; r < 6; r++)
        begin
            start = $unsigned($random(seed)) % storedStr.len();
            plen = 1 + $unsigned($random(seed)) % 5;
            if (start + plen > storedStr.len())
            begin
                plen = storedStr.len() - start;
            end
            p = storedStr.substr(start, start + plen - 1);
            if ($unsigned($random(seed)) % 3 == 0)
            begin
                p.putc($unsigned($random(seed)) % plen, `SME_DOT);
            end
            scanPattern(p);
        end
        reportTest("reuse", errorsBefore);
    endtask

    task automatic overlongPattern();
        int errorsBefore;
        errorsBefore = errorCount;
        loadString("abc");
        scanPattern("abcdefgh");
        scanPattern("abc");
        scanPattern("^abc$");
        reportTest("tooLong", errorsBefore);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        charData = '0;
        isString = 1'b0;
        isPattern = 1'b0;
        idleAfterReset();
        literalPatterns();
        dotWildcard();
        caretAnchor();
        dollarAnchor();
        stringReuse();
        overlongPattern();
        $display("tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verification/tbClock.sv
`timescale 1ns/10ps

module tbClock
#(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 16
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release a little after the edge, like the other inputs
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5 reset = 1'b0;
    end

endmodule

//--- design/smeTop.sv
`timescale 1ns/10ps
`include "sme_cfg.svh"

module smeTop import smePkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  smeChar  charData,
    input  logic    isString,
    input  logic    isPattern,
    output logic    valid,
    output logic    match,
    output smeIndex matchIndex
);

    smeWindow window;
    smePattern pattern;
    smeIndex scanIndex;
    logic [`SME_IDX_W:0] strLen;
    logic posMatch;
    logic clearPat;

    charStore charStore_i (
        .clk       (clk),
        .reset     (reset),
        .charData  (charData),
        .isString  (isString),
        .scanIndex (scanIndex),
        .pattern   (pattern),
        .window    (window),
        .strLen    (strLen)
    );

    patternStore patternStore_i (
        .clk       (clk),
        .reset     (reset),
        .charData  (charData),
        .isPattern (isPattern),
        .clearPat  (clearPat),
        .pattern   (pattern)
    );

    windowCompare windowCompare_i (
        .window    (window),
        .pattern   (pattern),
        .posMatch  (posMatch)
    );

    scanControl scanControl_i (
        .clk        (clk),
        .reset      (reset),
        .isString   (isString),
        .isPattern  (isPattern),
        .posMatch   (posMatch),
        .strLen     (strLen),
        .pattern    (pattern),
        .scanIndex  (scanIndex),
        .clearPat   (clearPat),
        .valid      (valid),
        .match      (match),
        .matchIndex (matchIndex)
    );

endmodule

//--- design/scanControl.sv
`timescale 1ns/10ps
`include "sme_cfg.svh"

module scanControl import smePkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                isString,
    input  logic                isPattern,
    input  logic                posMatch,
    input  logic [`SME_IDX_W:0] strLen,
    input  smePattern           pattern,
    output smeIndex             scanIndex,
    output logic                clearPat,
    output logic                valid,
    output logic                match,
    output smeIndex             matchIndex
);

    smeState state;
    smeState nextState;
    logic [`SME_IDX_W:0] coreLenW;
    logic [`SME_IDX_W:0] lastPos;
    logic tooLong;
    logic found;
    logic scanDone;
    logic loadStart;

    assign coreLenW = {2'b00, pattern.coreLen};
    assign tooLong = coreLenW > strLen;
    assign lastPos = strLen - coreLenW;

    // scan ends on the first hit or after the last fitting position
    assign found = posMatch && !tooLong;
    assign scanDone = (state == scan)
                      && (tooLong || found || ({1'b0, scanIndex} == lastPos));
    assign clearPat = scanDone;
    assign loadStart = (state == result) && (isString || isPattern);

    always_comb
    begin
        nextState = state;
        case (state)
            loadString:
            begin
                if (isPattern)
                begin
                    nextState = loadPattern;
                end
            end
            loadPattern:
            begin
                if (!isPattern)
                begin
                    nextState = scan;
                end
            end
            scan:
            begin
                if (scanDone)
                begin
                    nextState = result;
                end
            end
            result:
            begin
                // a new pattern may reuse the stored string
                if (isString)
                begin
                    nextState = loadString;
                end
                else if (isPattern)
                begin
                    nextState = loadPattern;
                end
            end
            default:
            begin
                nextState = loadString;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= loadString;
            scanIndex <= '0;
            valid <= 1'b0;
            match <= 1'b0;
            matchIndex <= '0;
        end
        else
        begin
            state <= nextState;
            valid <= scanDone;
            if (state == scan)
            begin
                scanIndex <= scanIndex + 1'b1;
            end
            else
            begin
                scanIndex <= '0;
            end
            if (scanDone)
            begin
                match <= found;
                matchIndex <= found ? scanIndex : '0;
            end
            else if (loadStart)
            begin
                match <= 1'b0;
                matchIndex <= '0;
            end
        end
    end

    // the scan has to end before the index wraps
    scanEnds: assert property (@(posedge clk) disable iff (reset)
        (state == scan && scanIndex == '1) |-> scanDone);

    // input must stay quiet until the result is out
    noLoadInScan: assert property (@(posedge clk) disable iff (reset)
        (state == scan) |-> !(isString || isPattern));

endmodule

//--- design/windowCompare.sv
`timescale 1ns/10ps
`include "sme_cfg.svh"

module windowCompare import smePkg::*;
(
    input  smeWindow  window,
    input  smePattern pattern,
    output logic      posMatch
);

    logic [`SME_PAT_LEN-1:0] agree;
    logic startOk;
    logic endOk;

    // unused core slots always agree
    always_comb
    begin
        for (int k = 0; k < `SME_PAT_LEN; k++)
        begin
            if (4'(k) >= pattern.coreLen)
            begin
                agree[k] = 1'b1;
            end
            else if (pattern.core[k] == `SME_DOT)
            begin
                agree[k] = 1'b1;
            end
            else
            begin
                agree[k] = (pattern.core[k] == window.chars[k]);
            end
        end
    end

    // ^ needs string start or a space before
    assign startOk = !pattern.anchorStart
                     || window.atStart
                     || (window.prevChar == `SME_SPACE);

    // $ needs string end or a space after the core
    assign endOk = !pattern.anchorEnd
                   || window.atEnd
                   || (window.endChar == `SME_SPACE);

    assign posMatch = (&agree) && startOk && endOk;

endmodule

//--- design/patternStore.sv
`timescale 1ns/10ps
`include "sme_cfg.svh"

module patternStore import smePkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  smeChar    charData,
    input  logic      isPattern,
    input  logic      clearPat,
    output smePattern pattern
);

    logic isPatternQ;
    logic patStart;
    logic patEnd;
    logic [2:0] lastIdx;
    logic trailingDollar;

    assign patStart = isPattern && !isPatternQ;
    assign patEnd = isPatternQ && !isPattern;

    // a $ is only an anchor once we know it was the final character
    assign lastIdx = 3'(pattern.coreLen - 4'd1);
    assign trailingDollar = (pattern.coreLen != 4'd0) && (pattern.core[lastIdx] == `SME_DOLLAR);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            isPatternQ <= 1'b0;
            pattern <= '0;
        end
        else
        begin
            isPatternQ <= isPattern;
            if (clearPat)
            begin
                pattern <= '0;
            end
            else if (patStart)
            begin
                pattern <= '0;
                if (charData == `SME_CARET)
                begin
                    pattern.anchorStart <= 1'b1;
                end
                else
                begin
                    pattern.core[0] <= charData;
                    pattern.coreLen <= 4'd1;
                end
            end
            else if (isPattern && pattern.coreLen < 4'(`SME_PAT_LEN))
            begin
                pattern.core[pattern.coreLen[2:0]] <= charData;
                pattern.coreLen <= pattern.coreLen + 4'd1;
            end
            else if (patEnd && trailingDollar)
            begin
                pattern.anchorEnd <= 1'b1;
                pattern.coreLen <= pattern.coreLen - 4'd1;
            end
        end
    end

endmodule

//--- design/charStore.sv
`timescale 1ns/10ps
`include "sme_cfg.svh"

module charStore import smePkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  smeChar               charData,
    input  logic                 isString,
    input  smeIndex              scanIndex,
    input  smePattern            pattern,
    output smeWindow             window,
    output logic [`SME_IDX_W:0]  strLen
);

    smeChar mem [`SME_STR_LEN];
    logic isStringQ;
    logic strStart;
    logic [`SME_IDX_W:0] writeCount;
    logic [`SME_IDX_W:0] wrAddr;
    logic [`SME_IDX_W:0] scanPos;
    logic [`SME_IDX_W:0] endPos;

    // first character of a new string goes to slot 0
    assign strStart = isString && !isStringQ;
    assign wrAddr = strStart ? '0 : writeCount;

    always_ff @(posedge clk)
    begin
        if (isString)
        begin
            mem[wrAddr[`SME_IDX_W-1:0]] <= charData;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            isStringQ <= 1'b0;
            writeCount <= '0;
            strLen <= '0;
        end
        else
        begin
            isStringQ <= isString;
            if (isString)
            begin
                writeCount <= wrAddr + 1'b1;
            end
            // length is latched on the falling edge of isString
            if (isStringQ && !isString)
            begin
                strLen <= writeCount;
            end
        end
    end

    // out-of-string positions read as space
    function automatic smeChar charAt(input logic [`SME_IDX_W:0] pos);
        if (pos < strLen)
        begin
            return mem[pos[`SME_IDX_W-1:0]];
        end
        return `SME_SPACE;
    endfunction

    assign scanPos = {1'b0, scanIndex};
    assign endPos = scanPos + {2'b00, pattern.coreLen};

    always_comb
    begin
        for (int k = 0; k < `SME_PAT_LEN; k++)
        begin
            window.chars[k] = charAt(scanPos + (`SME_IDX_W+1)'(k));
        end
        window.atStart = (scanIndex == '0);
        window.prevChar = window.atStart ? `SME_SPACE : charAt(scanPos - 1'b1);
        window.atEnd = (endPos == strLen);
        window.endChar = charAt(endPos);
    end

    stringFits: assert property (@(posedge clk) disable iff (reset)
        writeCount <= (`SME_IDX_W+1)'(`SME_STR_LEN));

endmodule

//--- design/smePkg.sv
`include "sme_cfg.svh"

package smePkg;

    typedef logic [`SME_CHAR_W-1:0] smeChar;

    // string position, also the reported match index
    typedef logic [`SME_IDX_W-1:0] smeIndex;

    // string characters seen from one scan position
    typedef struct packed {
        smeChar [`SME_PAT_LEN-1:0] chars;
        // character just before the scan position
        smeChar prevChar;
        // character just past the pattern core
        smeChar endChar;
        logic atStart;
        logic atEnd;
    } smeWindow;

    // pattern with its anchors stripped off
    typedef struct packed {
        smeChar [`SME_PAT_LEN-1:0] core;
        logic [3:0] coreLen;
        logic anchorStart;
        logic anchorEnd;
    } smePattern;

    typedef enum logic [1:0] {
        loadString,
        loadPattern,
        scan,
        result
    } smeState;

endpackage

//--- design/sme_cfg.svh
`ifndef SME_CFG_SVH
`define SME_CFG_SVH

// string and pattern capacity
`define SME_STR_LEN 32
`define SME_PAT_LEN 8

// character and string index widths
`define SME_CHAR_W 8
`define SME_IDX_W 5

// pattern metacharacters
`define SME_DOT 8'h2e
`define SME_CARET 8'h5e
`define SME_DOLLAR 8'h24

// word separator, also used as fill past the end of the string
`define SME_SPACE 8'h20

`endif
